/* src.f */
hw/fft_dims_pkg.sv
hw/fft_types_pkg.sv
hw/fft_if.sv
hw/fft_ctrl.sv
hw/fft_sample_mem.sv
hw/fft_twiddle_rom.sv
hw/fft_butterfly.sv
hw/fft_out_stream.sv
hw/fft_top.sv
tests/fft_assertions.sv
tests/fft_tb.sv

/* tests/fft_patterns.txt */
// Columns: input real, input imag, expected real, expected imag (hex, Q1.15)
// Line n gives input sample n and expected bin n, 16 lines per frame
// Frame 1: impulse of 0x2000 at sample 0
2000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
0000 0000 2000 0000
// Frame 2: DC, bin 4 and bin 8 tones, expected with truncated products and wrapping sums
1000 0000 11FE 00FE
FF80 0000 0702 FE00
FF00 0000 1600 F702
FF80 0000 0900 0A00
0400 0200 1DFE 00FE
FF80 0000 0702 FE00
FF00 0000 1600 F702
FF80 0000 0900 0A00
0800 FC00 19FE 00FE
FF80 0000 0702 FE00
FF00 0000 1600 F702
FF80 0000 0900 0A00
FE00 0300 1DFE 00FE
FF80 0000 0702 FE00
FF00 0000 1600 F702
FF80 0000 0900 0A00

/* tests/fft_tb.sv */
// Pattern file path is relative to the project root, so the simulator has to run from there
`timescale 1ns/1ps

module fft_tb
    import fft_dims_pkg::*;
();

    localparam int FRAMES     = 2;
    localparam int CLK_PERIOD = 4;
    // Load, four stages of issue plus flush, then unload
    localparam int FRAME_CYCLES = 2 * FFT_SIZE + FFT_STAGES * (FFT_HALF + FLUSH_CYCLES);
    localparam int WATCHDOG_NS  = 4 * FRAMES * FRAME_CYCLES * CLK_PERIOD;

    logic                       clk_i;
    logic                       rst_ni;
    logic signed [SAMPLE_W-1:0] data_real_i;
    logic signed [SAMPLE_W-1:0] data_imag_i;
    logic                       valid_i;
    logic                       ready_o;
    logic signed [SAMPLE_W-1:0] data_real_o;
    logic signed [SAMPLE_W-1:0] data_imag_o;
    logic                       valid_o;
    logic                       ready_i;
    logic                       busy_o;

    // Four words per line: input re, input im, expected re, expected im
    logic [SAMPLE_W-1:0] pat_mem [FRAMES*FFT_SIZE*4];

    logic [31:0] rng_state;
    int          errors;
    int          checks;

    fft_top u_dut (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .data_real_i(data_real_i),
        .data_imag_i(data_imag_i),
        .valid_i    (valid_i),
        .ready_o    (ready_o),
        .data_real_o(data_real_o),
        .data_imag_o(data_imag_o),
        .valid_o    (valid_o),
        .ready_i    (ready_i),
        .busy_o     (busy_o)
    );

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input int bin,
                               input logic [SAMPLE_W-1:0] exp, input logic [SAMPLE_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH at %0t: %s bin %0d expected %h got %h", $time, name, bin, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("ERROR at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // One frame: load with random gaps, unload with random stalls
    task automatic run_frame(input int f);
        int in_cnt;
        int out_cnt;
        int base;
        in_cnt  = 0;
        out_cnt = 0;
        base    = f * FFT_SIZE * 4;
        while (out_cnt < FFT_SIZE) begin
            @(negedge clk_i);
            if (in_cnt > 0) begin
                check_true(busy_o, "busy_o low while a frame is in flight");
            end
            if (in_cnt == FFT_SIZE) begin
                check_true(!ready_o, "ready_o high after the 16th sample");
            end else begin
                check_true(!valid_o, "valid_o high before all samples were loaded");
            end
            // Output side, transfer lands on the next rising edge
            rng_state = xorshift32(rng_state);
            ready_i   = (rng_state[1:0] != 2'b00);
            if (valid_o && ready_i) begin
                check_value("data_real_o", out_cnt, pat_mem[base + 4*out_cnt + 2], data_real_o);
                check_value("data_imag_o", out_cnt, pat_mem[base + 4*out_cnt + 3], data_imag_o);
                out_cnt++;
            end
            // Input side
            rng_state = xorshift32(rng_state);
            if (in_cnt < FFT_SIZE) begin
                valid_i = (rng_state[3:2] != 2'b00);
                if (valid_i) begin
                    data_real_i = pat_mem[base + 4*in_cnt];
                    data_imag_i = pat_mem[base + 4*in_cnt + 1];
                end else begin
                    data_real_i = rng_state[31:16];
                    data_imag_i = rng_state[15:0];
                end
                if (valid_i && ready_o) begin
                    in_cnt++;
                end
            end else if (out_cnt < FFT_SIZE) begin
                // Garbage during compute, must be refused
                valid_i     = rng_state[4];
                data_real_i = rng_state[31:16];
                data_imag_i = rng_state[15:0];
            end else begin
                // Last bin leaves on the next edge and the design goes idle
                valid_i = 1'b0;
            end
        end
        @(negedge clk_i);
        ready_i = 1'b0;
        check_true(!busy_o, "busy_o still high after the last bin");
        check_true(ready_o, "ready_o low after the last bin");
        check_true(!valid_o, "extra bin after the 16th");
    endtask

    // ========================================
    // Clock, stimulus and watchdog
    // ========================================
    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        rng_state   = 32'h26976620;
        errors      = 0;
        checks      = 0;
        rst_ni      = 1'b0;
        valid_i     = 1'b0;
        ready_i     = 1'b0;
        data_real_i = '0;
        data_imag_i = '0;
        $readmemh("tests/fft_patterns.txt", pat_mem);
        check_true(!$isunknown(pat_mem[FRAMES*FFT_SIZE*4-1]), "pattern file missing or short");
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // Idle state straight after reset
        check_true(!valid_o, "valid_o high after reset");
        check_true(!busy_o, "busy_o high after reset");
        check_true(ready_o, "ready_o low after reset");
        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_assertions.fail_cnt);
        if (errors == 0 && u_dut.u_assertions.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR at %0t: run did not finish within %0d ns", $time, WATCHDOG_NS);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors + 1, u_dut.u_assertions.fail_cnt);
        $display("sim failed");
        $finish;
    end

endmodule

/* tests/fft_assertions.sv */
// Checks only the top-level handshakes and stays silent while rst_ni is low
`timescale 1ns/1ps

module fft_assertions
    import fft_dims_pkg::*;
(
    input logic                clk_i,
    input logic                rst_ni,
    input logic                ready_o,
    input logic [SAMPLE_W-1:0] data_real_o,
    input logic [SAMPLE_W-1:0] data_imag_o,
    input logic                valid_o,
    input logic                ready_i,
    input logic                busy_o
);

    // Read by the testbench at the end of the run
    int fail_cnt = 0;

    // ========================================
    // Output handshake
    // ========================================

    // A stalled bin holds its place and value
    a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && !ready_i) |=> (valid_o && $stable(data_real_o) && $stable(data_imag_o)))
        else begin
            $error("output bin changed while ready_i was low");
            fail_cnt++;
        end

    // Bins only leave while a frame is in flight
    a_valid_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> busy_o)
        else begin
            $error("valid_o high while busy_o low");
            fail_cnt++;
        end

    // No new samples while bins are streaming
    a_valid_no_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> !ready_o)
        else begin
            $error("ready_o high while valid_o high");
            fail_cnt++;
        end

endmodule

bind fft_top fft_assertions u_assertions (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ready_o    (ready_o),
    .data_real_o(data_real_o),
    .data_imag_o(data_imag_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .busy_o     (busy_o)
);

/* hw/fft_top.sv */
// One frame at a time, and new samples are accepted only after the last bin of the previous frame
`timescale 1ns/1ps

module fft_top
    import fft_dims_pkg::*;
    import fft_types_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // Time-domain input
    input  logic signed [SAMPLE_W-1:0] data_real_i,
    input  logic signed [SAMPLE_W-1:0] data_imag_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    // Frequency bins
    output logic signed [SAMPLE_W-1:0] data_real_o,
    output logic signed [SAMPLE_W-1:0] data_imag_o,
    output logic                       valid_o,
    input  logic                       ready_i,
    output logic                       busy_o
);

    logic                  load_en;
    logic [FFT_ADDR_W-1:0] load_idx;
    cplx_t                 rd_a, rd_b;
    cplx_t                 tw;
    logic                  out_start;
    logic                  out_done;
    logic [FFT_ADDR_W-1:0] out_idx;
    cplx_t                 out_data;

    bf_issue_if issue_bus ();
    bf_wb_if    wb_bus ();

    // ========================================
    // Control and storage
    // ========================================
    fft_ctrl u_ctrl (
        .clk_i, .rst_ni, .valid_i, .ready_o, .busy_o,
        .load_en_o  (load_en),
        .load_idx_o (load_idx),
        .issue      (issue_bus.ctrl),
        .out_start_o(out_start),
        .out_done_i (out_done)
    );

    // Real part packs into the upper half of cplx_t
    fft_sample_mem u_mem (
        .clk_i, .rst_ni,
        .load_en_i  (load_en),
        .load_idx_i (load_idx),
        .load_data_i({data_real_i, data_imag_i}),
        .rd         (issue_bus.mem),
        .rd_a_o     (rd_a),
        .rd_b_o     (rd_b),
        .wb         (wb_bus.mem),
        .out_idx_i  (out_idx),
        .out_data_o (out_data)
    );

    // ========================================
    // Butterfly pipeline
    // ========================================
    fft_twiddle_rom u_rom (.clk_i, .rst_ni, .rd(issue_bus.rom), .tw_o(tw));

    fft_butterfly u_bfly (
        .clk_i, .rst_ni,
        .iss   (issue_bus.bfly),
        .op_a_i(rd_a),
        .op_b_i(rd_b),
        .tw_i  (tw),
        .wb    (wb_bus.bfly)
    );

    fft_out_stream u_out (
        .clk_i, .rst_ni,
        .start_i   (out_start),
        .done_o    (out_done),
        .out_idx_o (out_idx),
        .out_data_i(out_data),
        .data_real_o, .data_imag_o, .valid_o, .ready_i
    );

endmodule

/* hw/fft_out_stream.sv */
// Bins leave in natural order through a single output register and start only on a start pulse
`timescale 1ns/1ps

module fft_out_stream
    import fft_dims_pkg::*;
    import fft_types_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  start_i,
    output logic                  done_o,
    output logic [FFT_ADDR_W-1:0] out_idx_o,
    input  cplx_t                 out_data_i,
    output sample_t               data_real_o,
    output sample_t               data_imag_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    // Bins still to be fetched
    logic                  active_q;
    logic [FFT_ADDR_W-1:0] cnt_q;
    // Register holds bin 15
    logic                  last_q;
    logic                  xfer;
    logic                  load;

    assign xfer = valid_o && ready_i;
    // Refill when empty or when the current bin leaves
    assign load = active_q && (!valid_o || ready_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q    <= 1'b0;
            cnt_q       <= '0;
            last_q      <= 1'b0;
            valid_o     <= 1'b0;
            data_real_o <= '0;
            data_imag_o <= '0;
        end else begin
            if (start_i) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (load) begin
                data_real_o <= out_data_i.re;
                data_imag_o <= out_data_i.im;
                valid_o     <= 1'b1;
                last_q      <= (cnt_q == FFT_ADDR_W'(FFT_SIZE - 1));
                cnt_q       <= cnt_q + 1'b1;
                if (cnt_q == FFT_ADDR_W'(FFT_SIZE - 1)) begin
                    active_q <= 1'b0;
                end
            end else if (xfer) begin
                valid_o <= 1'b0;
                last_q  <= 1'b0;
            end
        end
    end

    assign out_idx_o = cnt_q;
    assign done_o    = xfer && last_q;

endmodule

/* hw/fft_butterfly.sv */
// Products are truncated to Q1.15 and sums wrap with no stage scaling, so large inputs overflow
`timescale 1ns/1ps

module fft_butterfly
    import fft_dims_pkg::*;
    import fft_types_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    bf_issue_if.bfly iss,
    input  cplx_t    op_a_i,
    input  cplx_t    op_b_i,
    input  cplx_t    tw_i,
    bf_wb_if.bfly    wb
);

    // ========================================
    // Alignment register
    // ========================================
    logic                  valid_q;
    logic [FFT_ADDR_W-1:0] idx_a_q, idx_b_q;
    cplx_t                 a_q, b_q;

    // Full-width products before truncation
    logic signed [2*SAMPLE_W-1:0] prod_re, prod_im;
    sample_t                      wb_re, wb_im;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= iss.issue_valid;
        end
    end

    // Operands and indices ride along with the strobe
    always_ff @(posedge clk_i) begin
        a_q     <= op_a_i;
        b_q     <= op_b_i;
        idx_a_q <= iss.idx_a;
        idx_b_q <= iss.idx_b;
    end

    // ========================================
    // Complex multiply W*B
    // ========================================
    assign prod_re = b_q.re * tw_i.re - b_q.im * tw_i.im;
    assign prod_im = b_q.re * tw_i.im + b_q.im * tw_i.re;

    // Keep bits 30 down to 15 of the Q2.30 product
    assign wb_re = prod_re[FRAC_W+SAMPLE_W-1:FRAC_W];
    assign wb_im = prod_im[FRAC_W+SAMPLE_W-1:FRAC_W];

    // ========================================
    // Radix-2 DIT outputs
    // ========================================
    // A' = A + WB, B' = A - WB
    assign wb.wb_valid = valid_q;
    assign wb.wb_idx_a = idx_a_q;
    assign wb.wb_idx_b = idx_b_q;
    assign wb.wb_a     = '{re: a_q.re + wb_re, im: a_q.im + wb_im};
    assign wb.wb_b     = '{re: a_q.re - wb_re, im: a_q.im - wb_im};

endmodule

/* hw/fft_twiddle_rom.sv */
// Table holds only the 8 twiddles of a 16-point transform, with W0 real part limited to 32767
`timescale 1ns/1ps

module fft_twiddle_rom
    import fft_dims_pkg::*;
    import fft_types_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    bf_issue_if.rom rd,
    output cplx_t  tw_o
);

    cplx_t tw_w;

    // W^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), Q1.15 rounded
    always_comb begin
        case (rd.tw_addr)
            3'd0:    tw_w = '{re: 16'h7FFF, im: 16'h0000};
            3'd1:    tw_w = '{re: 16'h7642, im: 16'hCF04};
            3'd2:    tw_w = '{re: 16'h5A82, im: 16'hA57E};
            3'd3:    tw_w = '{re: 16'h30FC, im: 16'h89BE};
            // Exactly -j
            3'd4:    tw_w = '{re: 16'h0000, im: 16'h8000};
            3'd5:    tw_w = '{re: 16'hCF04, im: 16'h89BE};
            3'd6:    tw_w = '{re: 16'hA57E, im: 16'hA57E};
            3'd7:    tw_w = '{re: 16'h89BE, im: 16'hCF04};
            default: tw_w = '0;
        endcase
    end

    // One cycle after the address, aligned with the butterfly operand register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tw_o <= '0;
        end else begin
            tw_o <= tw_w;
        end
    end

endmodule

/* hw/fft_sample_mem.sv */
// Reads are combinational and a load never coincides with a write-back, which the controller guarantees
`timescale 1ns/1ps

module fft_sample_mem
    import fft_dims_pkg::*;
    import fft_types_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Load port, index already bit-reversed
    input  logic                  load_en_i,
    input  logic [FFT_ADDR_W-1:0] load_idx_i,
    input  cplx_t                 load_data_i,
    // Butterfly operand reads
    bf_issue_if.mem               rd,
    output cplx_t                 rd_a_o,
    output cplx_t                 rd_b_o,
    // Butterfly results
    bf_wb_if.mem                  wb,
    // Output stream read
    input  logic [FFT_ADDR_W-1:0] out_idx_i,
    output cplx_t                 out_data_o
);

    // Single in-place buffer for the whole frame
    cplx_t mem_q [FFT_SIZE];

    // ========================================
    // Write ports
    // ========================================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < FFT_SIZE; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (load_en_i) begin
                mem_q[load_idx_i] <= load_data_i;
            end
            // Both legs of a butterfly write on the same edge
            if (wb.wb_valid) begin
                mem_q[wb.wb_idx_a] <= wb.wb_a;
                mem_q[wb.wb_idx_b] <= wb.wb_b;
            end
        end
    end

    // ========================================
    // Read ports
    // ========================================
    assign rd_a_o     = mem_q[rd.idx_a];
    assign rd_b_o     = mem_q[rd.idx_b];
    assign out_data_o = mem_q[out_idx_i];

endmodule

/* hw/fft_ctrl.sv */
// Input is refused outside IDLE and LOADING and each stage takes a fixed 10 cycles with no early exit
`timescale 1ns/1ps

module fft_ctrl
    import fft_dims_pkg::*;
    import fft_types_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  valid_i,
    output logic                  ready_o,
    output logic                  busy_o,
    output logic                  load_en_o,
    output logic [FFT_ADDR_W-1:0] load_idx_o,
    bf_issue_if.ctrl              issue,
    output logic                  out_start_o,
    input  logic                  out_done_i
);

    fft_state_t state_q, state_d;

    logic [FFT_ADDR_W-1:0]         in_cnt_q;
    logic [$clog2(FFT_STAGES)-1:0] stage_q;
    // Counts issues then flush cycles within a stage
    logic [FFT_ADDR_W-1:0]         bf_cnt_q;
    logic                          accept;
    logic                          flush_end;
    logic                          last_stage;
    logic                          out_start_q;

    // Issue registers
    logic                  issue_valid_q;
    logic [FFT_ADDR_W-1:0] idx_a_q, idx_b_q;
    logic [TW_ADDR_W-1:0]  tw_addr_q;

    // Address terms for the current butterfly
    logic [FFT_ADDR_W-1:0] half_w, pos_w, grp_w, base_w;
    logic [TW_ADDR_W-1:0]  tw_w;

    function automatic logic [FFT_ADDR_W-1:0] bit_rev(input logic [FFT_ADDR_W-1:0] v);
        logic [FFT_ADDR_W-1:0] r;
        for (int i = 0; i < FFT_ADDR_W; i++) begin
            r[i] = v[FFT_ADDR_W-1-i];
        end
        return r;
    endfunction

    // ========================================
    // Handshake and load path
    // ========================================
    assign ready_o    = (state_q == IDLE) || (state_q == LOADING);
    assign busy_o     = (state_q != IDLE);
    assign accept     = ready_o && valid_i;
    assign load_en_o  = accept;
    // Samples land bit-reversed so stage 0 reads in natural order
    assign load_idx_o = bit_rev(in_cnt_q);

    assign flush_end  = (bf_cnt_q == FFT_ADDR_W'(FFT_HALF + FLUSH_CYCLES - 1));
    assign last_stage = (stage_q == $bits(stage_q)'(FFT_STAGES - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, LOADING: begin
                if (accept) begin
                    state_d = (in_cnt_q == FFT_ADDR_W'(FFT_SIZE - 1)) ? PROCESSING : LOADING;
                end
            end
            PROCESSING: begin
                if (flush_end && last_stage) begin
                    state_d = OUTPUTTING;
                end
            end
            OUTPUTTING: begin
                if (out_done_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // ========================================
    // Butterfly addressing
    // ========================================
    always_comb begin
        // Span between the two legs doubles every stage
        half_w = FFT_ADDR_W'(1) << stage_q;
        pos_w  = bf_cnt_q & (half_w - FFT_ADDR_W'(1));
        grp_w  = bf_cnt_q >> stage_q;
        base_w = (grp_w << (stage_q + 1)) | pos_w;
        tw_w   = TW_ADDR_W'(pos_w * (FFT_SIZE >> (stage_q + 1)));
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= IDLE;
            in_cnt_q      <= '0;
            stage_q       <= '0;
            bf_cnt_q      <= '0;
            out_start_q   <= 1'b0;
            issue_valid_q <= 1'b0;
            idx_a_q       <= '0;
            idx_b_q       <= '0;
            tw_addr_q     <= '0;
        end else begin
            state_q     <= state_d;
            out_start_q <= (state_q == PROCESSING) && (state_d == OUTPUTTING);
            // Wraps to zero after the 16th sample
            if (accept) begin
                in_cnt_q <= in_cnt_q + 1'b1;
            end
            if (state_q == PROCESSING) begin
                if (bf_cnt_q < FFT_HALF) begin
                    issue_valid_q <= 1'b1;
                    idx_a_q       <= base_w;
                    idx_b_q       <= base_w + half_w;
                    tw_addr_q     <= tw_w;
                    bf_cnt_q      <= bf_cnt_q + 1'b1;
                end else begin
                    // Flush so the next stage reads written results
                    issue_valid_q <= 1'b0;
                    if (flush_end) begin
                        bf_cnt_q <= '0;
                        stage_q  <= stage_q + 1'b1;
                    end else begin
                        bf_cnt_q <= bf_cnt_q + 1'b1;
                    end
                end
            end else begin
                issue_valid_q <= 1'b0;
                bf_cnt_q      <= '0;
                stage_q       <= '0;
            end
        end
    end

    assign issue.issue_valid = issue_valid_q;
    assign issue.idx_a       = idx_a_q;
    assign issue.idx_b       = idx_b_q;
    assign issue.tw_addr     = tw_addr_q;
    assign out_start_o       = out_start_q;

endmodule

/* hw/fft_if.sv */
// Both buses are unhandshaked strobes and rely on the controller flush to avoid read-after-write hazards
`timescale 1ns/1ps

// Butterfly issue bus from the controller
// One strobe per butterfly, addresses valid in the same cycle
interface bf_issue_if import fft_dims_pkg::*; ();

    logic                  issue_valid;
    logic [FFT_ADDR_W-1:0] idx_a;
    logic [FFT_ADDR_W-1:0] idx_b;
    logic [TW_ADDR_W-1:0]  tw_addr;

    modport ctrl (output issue_valid, output idx_a, output idx_b, output tw_addr);
    // Buffer only needs the two read addresses
    modport mem  (input idx_a, input idx_b);
    modport rom  (input tw_addr);
    modport bfly (input issue_valid, input idx_a, input idx_b);

endinterface

// Write-back bus from the butterfly into the buffer
// wb_valid writes both entries on the same edge
interface bf_wb_if import fft_dims_pkg::*, fft_types_pkg::*; ();

    logic                  wb_valid;
    logic [FFT_ADDR_W-1:0] wb_idx_a;
    logic [FFT_ADDR_W-1:0] wb_idx_b;
    cplx_t                 wb_a;
    cplx_t                 wb_b;

    modport bfly (output wb_valid, output wb_idx_a, output wb_idx_b,
                  output wb_a, output wb_b);
    modport mem  (input wb_valid, input wb_idx_a, input wb_idx_b,
                  input wb_a, input wb_b);

endinterface

/* hw/fft_types_pkg.sv */
// Samples are signed Q1.15 with no guard bits, so sums wrap and frames must leave headroom
package fft_types_pkg;

    import fft_dims_pkg::*;

    // ========================================
    // Data types
    // ========================================

    // One signed part of a complex sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Complex sample, real part in the upper half
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_t;

    // ========================================
    // Controller states
    // ========================================

    // IDLE and LOADING accept input
    // PROCESSING runs the four butterfly stages
    // OUTPUTTING streams bins until the last transfer
    typedef enum logic [1:0] {
        IDLE,
        LOADING,
        PROCESSING,
        OUTPUTTING
    } fft_state_t;

endpackage

/* hw/fft_dims_pkg.sv */
// Sizes are fixed for a 16-point transform and the twiddle table is written for exactly these values
package fft_dims_pkg;

    // ========================================
    // Transform size
    // ========================================

    // Number of complex points in one frame
    localparam int FFT_SIZE = 16;
    // log2 of FFT_SIZE
    localparam int FFT_STAGES = 4;
    // Sample buffer address width
    localparam int FFT_ADDR_W = 4;
    // Butterflies per stage, also the twiddle table depth
    localparam int FFT_HALF = 8;
    localparam int TW_ADDR_W = 3;

    // ========================================
    // Number format
    // ========================================

    // One real or imaginary part, Q1.15
    localparam int SAMPLE_W = 16;
    localparam int FRAC_W = 15;

    // Idle cycles after the last butterfly of a stage
    // Covers the two-cycle issue to write-back path
    localparam int FLUSH_CYCLES = 2;

endpackage
